/* ctrlport_decoder.sv */
// ----------------------------------------
// Control port address decoder
// Steers one request port to at most one of
// NUM_SLAVES endpoints by address and merges
// their responses into one, both registered
// ----------------------------------------

`timescale 1ns/1ps

module ctrlport_decoder #(
  parameter int                           NUM_SLAVES   = 2,
  parameter ctrlport_pkg::ctrlport_addr_t BASE_ADDR    = '0,
  parameter int                           SLAVE_ADDR_W = 8
) (
  input  logic                                          ctrlport_clk,
  input  logic                                          ctrlport_rst,
  input  ctrlport_pkg::ctrlport_req_t                   s_req,
  output ctrlport_pkg::ctrlport_resp_t                  s_resp,
  output ctrlport_pkg::ctrlport_req_t  [NUM_SLAVES-1:0] m_req,
  input  ctrlport_pkg::ctrlport_resp_t [NUM_SLAVES-1:0] m_resp
);

  // Address layout, from the top bit down
  //   base bits | port number bits | endpoint offset bits
  localparam int ADDR_W        = ctrlport_pkg::CTRLPORT_ADDR_W;
  localparam int PORT_NUM_W    = $clog2(NUM_SLAVES);
  localparam int PORT_NUM_POS  = SLAVE_ADDR_W;
  localparam int BASE_ADDR_POS = SLAVE_ADDR_W + PORT_NUM_W;
  localparam int BASE_ADDR_W   = ADDR_W - BASE_ADDR_POS;

  // Selects only the base bits of an address
  localparam ctrlport_pkg::ctrlport_addr_t BASE_ADDR_MASK =
    ctrlport_pkg::ctrlport_addr_t'({BASE_ADDR_W{1'b1}}) << BASE_ADDR_POS;

  // ----------------------------------------
  // Request split
  // ----------------------------------------

  logic [NUM_SLAVES-1:0] hit;
  logic [NUM_SLAVES-1:0] wr_q;
  logic [NUM_SLAVES-1:0] rd_q;

  ctrlport_pkg::ctrlport_addr_t    addr_q;
  ctrlport_pkg::ctrlport_data_t    data_q;
  ctrlport_pkg::ctrlport_byte_en_t byte_en_q;
  logic                            has_time_q;
  ctrlport_pkg::ctrlport_time_t    time_q;

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : gen_hit
    if (PORT_NUM_W == 0) begin : gen_single
      // With a single endpoint there are no port number bits to compare
      assign hit[i] = ((s_req.addr & BASE_ADDR_MASK) == BASE_ADDR);
    end else begin : gen_multi
      assign hit[i] = ((s_req.addr & BASE_ADDR_MASK) == BASE_ADDR) &&
                      (s_req.addr[PORT_NUM_POS +: PORT_NUM_W] == PORT_NUM_W'(i));
    end
  end

  // Strobes reach only the endpoint whose address range matches
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      wr_q <= '0;
      rd_q <= '0;
    end else begin
      wr_q <= {NUM_SLAVES{s_req.wr}} & hit;
      rd_q <= {NUM_SLAVES{s_req.rd}} & hit;
    end
  end

  // Payload is shared by all endpoints and only means something under a strobe
  // The endpoint sees its own offset, with the upper address bits cleared
  always_ff @(posedge ctrlport_clk) begin
    addr_q     <= ctrlport_pkg::ctrlport_addr_t'(s_req.addr[SLAVE_ADDR_W-1:0]);
    data_q     <= s_req.data;
    byte_en_q  <= s_req.byte_en;
    has_time_q <= s_req.has_time;
    time_q     <= s_req.timestamp;
  end

  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      m_req[i].wr        = wr_q[i];
      m_req[i].rd        = rd_q[i];
      m_req[i].addr      = addr_q;
      m_req[i].data      = data_q;
      m_req[i].byte_en   = byte_en_q;
      m_req[i].has_time  = has_time_q;
      m_req[i].timestamp = time_q;
    end
  end

  // ----------------------------------------
  // Response merge
  // ----------------------------------------

  logic                         ack_or;
  logic [1:0]                   status_or;
  ctrlport_pkg::ctrlport_data_t data_or;

  logic                           ack_q;
  ctrlport_pkg::ctrlport_status_t status_q;
  ctrlport_pkg::ctrlport_data_t   resp_data_q;

  // Only an acking endpoint contributes, so idle endpoints can drive anything
  always_comb begin
    ack_or    = 1'b0;
    status_or = '0;
    data_or   = '0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      ack_or    = ack_or | m_resp[s].ack;
      status_or = status_or | (m_resp[s].status & {2{m_resp[s].ack}});
      data_or   = data_or | (m_resp[s].data & {ctrlport_pkg::CTRLPORT_DATA_W{m_resp[s].ack}});
    end
  end

  // The merged response is registered to cut the path back to the master
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_or;
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    status_q    <= ctrlport_pkg::ctrlport_status_t'(status_or);
    resp_data_q <= data_or;
  end

  assign s_resp.ack    = ack_q;
  assign s_resp.status = status_q;
  assign s_resp.data   = resp_data_q;

endmodule

/* ctrlport_pkg.sv */
// ----------------------------------------
// Control port package
// Widths, status codes and the request and
// response structs shared by every block of
// the control port subsystem
// ----------------------------------------

package ctrlport_pkg;

  // ----------------------------------------
  // Field widths
  // ----------------------------------------

  // Every control port address is 20 bits wide
  localparam int CTRLPORT_ADDR_W = 20;

  // Data words are 32 bits, split into four byte lanes
  localparam int CTRLPORT_DATA_W = 32;
  localparam int CTRLPORT_BYTE_EN_W = CTRLPORT_DATA_W / 8;

  // Timestamps follow the 64-bit time format of the bus
  localparam int CTRLPORT_TIME_W = 64;

  // ----------------------------------------
  // Plain vector types
  // ----------------------------------------

  typedef logic [CTRLPORT_ADDR_W-1:0] ctrlport_addr_t;
  typedef logic [CTRLPORT_DATA_W-1:0] ctrlport_data_t;
  typedef logic [CTRLPORT_BYTE_EN_W-1:0] ctrlport_byte_en_t;
  typedef logic [CTRLPORT_TIME_W-1:0] ctrlport_time_t;

  // Response status codes, encoded as on the bus
  typedef enum logic [1:0] {
    sts_okay    = 2'd0,
    sts_cmderr  = 2'd1,
    sts_tserr   = 2'd2,
    sts_warning = 2'd3
  } ctrlport_status_t;

  // ----------------------------------------
  // Request and response bundles
  // ----------------------------------------

  // A request is a single-cycle pulse on wr or rd, with the rest as payload
  // The timestamp field only matters when has_time is set
  typedef struct packed {
    logic              wr;
    logic              rd;
    ctrlport_addr_t    addr;
    ctrlport_data_t    data;
    ctrlport_byte_en_t byte_en;
    logic              has_time;
    ctrlport_time_t    timestamp;
  } ctrlport_req_t;

  // A response is a single-cycle ack, with status and data valid alongside it
  typedef struct packed {
    logic             ack;
    ctrlport_status_t status;
    ctrlport_data_t   data;
  } ctrlport_resp_t;

endpackage

/* ctrlport_reg_bank.sv */
// ----------------------------------------
// Control port register bank
// Scratch register, identity word and a
// counter of successful writes
// ----------------------------------------

`timescale 1ns/1ps

module ctrlport_reg_bank #(
  parameter ctrlport_pkg::ctrlport_data_t ID_VALUE = '0
) (
  input  logic                         ctrlport_clk,
  input  logic                         ctrlport_rst,
  input  ctrlport_pkg::ctrlport_req_t  s_req,
  output ctrlport_pkg::ctrlport_resp_t s_resp
);

  // Register offsets within the bank
  localparam ctrlport_pkg::ctrlport_addr_t REG_SCRATCH = 'h00;
  localparam ctrlport_pkg::ctrlport_addr_t REG_ID      = 'h04;
  localparam ctrlport_pkg::ctrlport_addr_t REG_COUNT   = 'h08;

  localparam int NUM_BYTES = ctrlport_pkg::CTRLPORT_BYTE_EN_W;

  ctrlport_pkg::ctrlport_data_t   scratch;
  ctrlport_pkg::ctrlport_data_t   wr_count;
  ctrlport_pkg::ctrlport_status_t status_d;
  ctrlport_pkg::ctrlport_data_t   rdata_d;
  logic                           scratch_we;
  logic                           count_inc;

  logic                           ack_q;
  ctrlport_pkg::ctrlport_status_t status_q;
  ctrlport_pkg::ctrlport_data_t   rdata_q;

  // ----------------------------------------
  // Access decode
  // ----------------------------------------

  always_comb begin
    status_d   = ctrlport_pkg::sts_okay;
    rdata_d    = '0;
    scratch_we = 1'b0;
    if (s_req.has_time) begin
      // Timed execution is not supported, so the request has no effect
      status_d = ctrlport_pkg::sts_tserr;
    end else begin
      case (s_req.addr)
        REG_SCRATCH: begin
          scratch_we = s_req.wr;
          rdata_d    = scratch;
        end
        REG_ID: begin
          rdata_d = ID_VALUE;
          if (s_req.wr) status_d = ctrlport_pkg::sts_cmderr;
        end
        REG_COUNT: begin
          // The counter is read only as well
          rdata_d = wr_count;
          if (s_req.wr) status_d = ctrlport_pkg::sts_cmderr;
        end
        default: status_d = ctrlport_pkg::sts_cmderr;
      endcase
    end
    // Data is returned only by successful reads
    if (!s_req.rd || status_d != ctrlport_pkg::sts_okay) rdata_d = '0;
  end

  assign count_inc = s_req.wr && (status_d == ctrlport_pkg::sts_okay);

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      scratch  <= '0;
      wr_count <= '0;
    end else begin
      // Each enabled byte lane replaces its part of the scratch word
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (scratch_we && s_req.byte_en[b]) scratch[8*b +: 8] <= s_req.data[8*b +: 8];
      end
      if (count_inc) wr_count <= wr_count + 1'b1;
    end
  end

  // One-cycle ack for every request
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= s_req.wr || s_req.rd;
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    status_q <= status_d;
    rdata_q  <= rdata_d;
  end

  assign s_resp.ack    = ack_q;
  assign s_resp.status = status_q;
  assign s_resp.data   = rdata_q;

endmodule

/* ctrlport_scratch_ram.sv */
// ----------------------------------------
// Control port scratch RAM
// 64-word memory with byte-lane writes,
// always answering with okay status
// ----------------------------------------

`timescale 1ns/1ps

module ctrlport_scratch_ram (
  input  logic                         ctrlport_clk,
  input  logic                         ctrlport_rst,
  input  ctrlport_pkg::ctrlport_req_t  s_req,
  output ctrlport_pkg::ctrlport_resp_t s_resp
);

  localparam int DEPTH     = 64;
  localparam int IDX_W     = $clog2(DEPTH);
  localparam int NUM_BYTES = ctrlport_pkg::CTRLPORT_BYTE_EN_W;

  // Word index sits just above the byte offset
  localparam int IDX_LSB = 2;

  ctrlport_pkg::ctrlport_data_t mem [DEPTH];

  logic [IDX_W-1:0]             word_idx;
  logic                         ack_q;
  ctrlport_pkg::ctrlport_data_t rdata_q;

  assign word_idx = s_req.addr[IDX_LSB +: IDX_W];

  // ----------------------------------------
  // Memory array
  // ----------------------------------------

  // Writes touch only the enabled byte lanes of the addressed word
  always_ff @(posedge ctrlport_clk) begin
    if (s_req.wr) begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (s_req.byte_en[b]) mem[word_idx][8*b +: 8] <= s_req.data[8*b +: 8];
      end
    end
  end

  // Read data is captured on every request
  // Writes answer with zero data
  always_ff @(posedge ctrlport_clk) begin
    if (s_req.rd) begin
      rdata_q <= mem[word_idx];
    end else if (s_req.wr) begin
      rdata_q <= '0;
    end
  end

  // ----------------------------------------
  // Response
  // ----------------------------------------

  // Ack follows the request by one cycle
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= s_req.wr || s_req.rd;
    end
  end

  // Every access to the RAM succeeds
  assign s_resp.ack    = ack_q;
  assign s_resp.status = ctrlport_pkg::sts_okay;
  assign s_resp.data   = rdata_q;

endmodule

/* ctrlport_sub.f */
ctrlport_pkg.sv
ctrlport_timeout.sv
ctrlport_decoder.sv
ctrlport_reg_bank.sv
ctrlport_scratch_ram.sv
ctrlport_sub.sv
ctrlport_sub_sva.sv
ctrlport_sub_tb.sv

/* ctrlport_sub.sv */
// ----------------------------------------
// Control port subsystem top level
// Watchdog, address decoder, register bank
// and scratch RAM behind one master port
// ----------------------------------------

`timescale 1ns/1ps

module ctrlport_sub #(
  parameter int                           NUM_SLAVES     = 2,
  parameter ctrlport_pkg::ctrlport_addr_t BASE_ADDR      = 20'h80000,
  parameter int                           SLAVE_ADDR_W   = 8,
  parameter int                           TIMEOUT_CYCLES = 16,
  parameter ctrlport_pkg::ctrlport_data_t ID_VALUE       = 32'h5AB0_0001
) (
  input  logic                         ctrlport_clk,
  input  logic                         ctrlport_rst,
  input  ctrlport_pkg::ctrlport_req_t  s_req,
  output ctrlport_pkg::ctrlport_resp_t s_resp
);

  // Between watchdog and decoder
  ctrlport_pkg::ctrlport_req_t  wd_req;
  ctrlport_pkg::ctrlport_resp_t wd_resp;

  // Between decoder and endpoints, port 0 is the register bank and port 1 the RAM
  ctrlport_pkg::ctrlport_req_t  [NUM_SLAVES-1:0] ep_req;
  ctrlport_pkg::ctrlport_resp_t [NUM_SLAVES-1:0] ep_resp;

  // Unmapped requests are answered here
  ctrlport_timeout #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) timeout_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .s_req        (s_req),
    .s_resp       (s_resp),
    .m_req        (wd_req),
    .m_resp       (wd_resp)
  );

  ctrlport_decoder #(
    .NUM_SLAVES   (NUM_SLAVES),
    .BASE_ADDR    (BASE_ADDR),
    .SLAVE_ADDR_W (SLAVE_ADDR_W)
  ) decoder_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .s_req        (wd_req),
    .s_resp       (wd_resp),
    .m_req        (ep_req),
    .m_resp       (ep_resp)
  );

  ctrlport_reg_bank #(
    .ID_VALUE (ID_VALUE)
  ) reg_bank_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .s_req        (ep_req[0]),
    .s_resp       (ep_resp[0])
  );

  ctrlport_scratch_ram scratch_ram_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .s_req        (ep_req[1]),
    .s_resp       (ep_resp[1])
  );

endmodule

/* ctrlport_sub_stim.txt */
// op addr data byte_en has_time exp_status exp_rdata, op 1 write, 2 read, 0 ends the list
// status 0 okay, 1 cmderr, 2 tserr; all values in hex
1 80000 11223344 f 0 0 00000000
1 80000 aabbccdd 5 0 0 00000000
2 80000 00000000 0 0 0 11bb33dd
1 80000 99887766 8 0 0 00000000
2 80000 00000000 0 0 0 99bb33dd
2 80004 00000000 0 0 0 5ab00001
1 80004 12345678 f 0 1 00000000
2 80008 00000000 0 0 0 00000003
1 8000c deadbeef f 0 1 00000000
1 80008 00000001 f 0 1 00000000
2 80010 00000000 0 0 1 00000000
2 80008 00000000 0 0 0 00000003
1 80000 00000000 f 1 2 00000000
2 80000 00000000 0 1 2 00000000
2 80000 00000000 0 0 0 99bb33dd
2 80008 00000000 0 0 0 00000003
1 80100 01020304 f 0 0 00000000
1 80100 a0b0c0d0 2 0 0 00000000
1 80104 cafef00d f 0 0 00000000
1 80104 11111111 9 0 0 00000000
1 801fc 55aa55aa f 0 0 00000000
1 801fc 0000ffff 4 0 0 00000000
2 80100 00000000 0 0 0 0102c004
2 80104 00000000 0 0 0 11fef011
2 801fc 00000000 0 0 0 550055aa
2 00010 00000000 0 0 1 00000000
1 80200 12345678 f 0 1 00000000
2 80100 00000000 0 0 0 0102c004
2 80008 00000000 0 0 0 00000003
0 00000 00000000 0 0 0 00000000

/* ctrlport_sub_sva.sv */
// ----------------------------------------
// Control port protocol assertions
// Strobe, ack and single outstanding request
// rules at the subsystem master port
// ----------------------------------------

`timescale 1ns/1ps

module ctrlport_sub_sva (
  input logic                         ctrlport_clk,
  input logic                         ctrlport_rst,
  input ctrlport_pkg::ctrlport_req_t  s_req,
  input ctrlport_pkg::ctrlport_resp_t s_resp
);

  // High from the cycle after a request up to and including the cycle of its ack
  logic outstanding;

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      outstanding <= 1'b0;
    end else if (s_req.wr || s_req.rd) begin
      outstanding <= 1'b1;
    end else if (s_resp.ack) begin
      outstanding <= 1'b0;
    end
  end

  no_wr_and_rd: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    !(s_req.wr && s_req.rd)) else $error("Write and read strobes high in the same cycle");

  ack_one_cycle: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    s_resp.ack |=> !s_resp.ack) else $error("Ack held high for more than one cycle");

  // The port has no back-pressure, so a second request would be lost
  no_overlap: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    outstanding |-> !(s_req.wr || s_req.rd)) else $error("New request before the last ack");

  ack_has_request: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    s_resp.ack |-> outstanding) else $error("Ack without an outstanding request");

endmodule

bind ctrlport_sub ctrlport_sub_sva sva_i (
  .ctrlport_clk (ctrlport_clk),
  .ctrlport_rst (ctrlport_rst),
  .s_req        (s_req),
  .s_resp       (s_resp)
);

/* ctrlport_sub_tb.sv */
// ----------------------------------------
// Control port subsystem testbench
// Replays requests from the stimulus file
// and checks status, read data and latency
// ----------------------------------------

`timescale 1ns/1ps

module ctrlport_sub_tb;

  // Record layout of the stimulus file, seven words per request
  localparam int NUM_FIELDS = 7;
  localparam int F_OP       = 0;
  localparam int F_ADDR     = 1;
  localparam int F_DATA     = 2;
  localparam int F_BYTE_EN  = 3;
  localparam int F_HAS_TIME = 4;
  localparam int F_STATUS   = 5;
  localparam int F_RDATA    = 6;
  localparam int MAX_REQS   = 40;

  // Response timing of the subsystem
  localparam int ACK_TIMEOUT      = 40;
  localparam int MAPPED_LATENCY   = 3;
  localparam int UNMAPPED_LATENCY = 16;

  // Both endpoints together cover one contiguous window
  localparam logic [19:0] MAPPED_FIRST = 20'h80000;
  localparam logic [19:0] MAPPED_LAST  = 20'h801FF;

  logic                         ctrlport_clk;
  logic                         ctrlport_rst;
  ctrlport_pkg::ctrlport_req_t  s_req;
  ctrlport_pkg::ctrlport_resp_t s_resp;

  logic [31:0] stim [0:NUM_FIELDS*MAX_REQS-1];

  int error_count;
  int mismatch_count;
  int timeout_count;
  int check_count;
  bit timed_out;

  ctrlport_sub #(
    .NUM_SLAVES     (2),
    .BASE_ADDR      (20'h80000),
    .SLAVE_ADDR_W   (8),
    .TIMEOUT_CYCLES (16),
    .ID_VALUE       (32'h5AB0_0001)
  ) dut_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .s_req        (s_req),
    .s_resp       (s_resp)
  );

  // 20 ns clock period
  initial begin
    ctrlport_clk = 1'b0;
    forever #10 ctrlport_clk = ~ctrlport_clk;
  end

  // ----------------------------------------
  // One request and its response check
  // ----------------------------------------

  // Issues record idx as a one-cycle strobe, then waits for the ack
  // Outputs are sampled on the falling edge, away from the register updates
  task automatic run_request(input int idx);
    int                          base;
    int                          exp_latency;
    int                          latency;
    bit                          got_ack;
    logic [1:0]                  got_status;
    logic [31:0]                 got_data;
    ctrlport_pkg::ctrlport_req_t req;
    base        = idx * NUM_FIELDS;
    req         = '0;
    req.wr      = (stim[base + F_OP] == 32'd1);
    req.rd      = (stim[base + F_OP] == 32'd2);
    req.addr    = stim[base + F_ADDR][19:0];
    req.data    = stim[base + F_DATA];
    req.byte_en = stim[base + F_BYTE_EN][3:0];
    req.has_time  = stim[base + F_HAS_TIME][0];
    req.timestamp = 64'(idx);
    // Nothing outside the endpoint window answers, so the watchdog does
    if ((req.addr >= MAPPED_FIRST) && (req.addr <= MAPPED_LAST)) begin
      exp_latency = MAPPED_LATENCY;
    end else begin
      exp_latency = UNMAPPED_LATENCY;
    end
    @(posedge ctrlport_clk);
    s_req <= req;
    @(posedge ctrlport_clk);
    s_req.wr <= 1'b0;
    s_req.rd <= 1'b0;
    latency    = 1;
    got_ack    = 1'b0;
    got_status = '0;
    got_data   = '0;
    while (!got_ack && (latency <= ACK_TIMEOUT)) begin
      @(negedge ctrlport_clk);
      if (s_resp.ack) begin
        got_ack    = 1'b1;
        got_status = s_resp.status;
        got_data   = s_resp.data;
      end else begin
        @(posedge ctrlport_clk);
        latency++;
      end
    end
    if (!got_ack) begin
      $display("Request %0d to address %05h got no ack within %0d cycles", idx, req.addr,
               ACK_TIMEOUT);
      timeout_count++;
      error_count++;
      timed_out = 1'b1;
    end else begin
      check_count++;
      if (latency != exp_latency) begin
        $display("MISMATCH at %0t: request %0d to %05h acked after %0d cycles, expected %0d",
                 $time, idx, req.addr, latency, exp_latency);
        mismatch_count++;
        error_count++;
      end
      if (got_status != stim[base + F_STATUS][1:0]) begin
        $display("MISMATCH at %0t: request %0d to %05h status %0d, expected %0d",
                 $time, idx, req.addr, got_status, stim[base + F_STATUS][1:0]);
        mismatch_count++;
        error_count++;
      end
      if (got_data != stim[base + F_RDATA]) begin
        $display("MISMATCH at %0t: request %0d to %05h data %08h, expected %08h",
                 $time, idx, req.addr, got_data, stim[base + F_RDATA]);
        mismatch_count++;
        error_count++;
      end
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    int idx;
    error_count    = 0;
    mismatch_count = 0;
    timeout_count  = 0;
    check_count    = 0;
    timed_out      = 1'b0;
    ctrlport_rst   = 1'b1;
    s_req          = '0;
    $readmemh("ctrlport_sub_stim.txt", stim);
    repeat (16) @(posedge ctrlport_clk);
    ctrlport_rst <= 1'b0;
    // No ack may be left over from reset
    @(negedge ctrlport_clk);
    if (s_resp.ack != 1'b0) begin
      $display("MISMATCH at %0t: ack is high right after reset", $time);
      mismatch_count++;
      error_count++;
    end
    // An operation code of zero closes the list, and a timeout ends the run early
    idx = 0;
    while ((idx < MAX_REQS) && (stim[idx * NUM_FIELDS + F_OP] != 32'd0) && !timed_out) begin
      run_request(idx);
      idx++;
    end
    if (idx == 0) begin
      $display("No requests were read from the stimulus file");
      error_count++;
    end
    $display("Requests: %0d, checks: %0d, mismatches: %0d, timeouts: %0d, errors: %0d",
             idx, check_count, mismatch_count, timeout_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* ctrlport_timeout.sv */
// ----------------------------------------
// Control port response watchdog
// Forwards requests untouched and answers
// any request left without an ack with a
// command error after a fixed delay
// ----------------------------------------

`timescale 1ns/1ps

module ctrlport_timeout #(
  parameter int TIMEOUT_CYCLES = 16
) (
  input  logic                         ctrlport_clk,
  input  logic                         ctrlport_rst,
  input  ctrlport_pkg::ctrlport_req_t  s_req,
  output ctrlport_pkg::ctrlport_resp_t s_resp,
  output ctrlport_pkg::ctrlport_req_t  m_req,
  input  ctrlport_pkg::ctrlport_resp_t m_resp
);

  // The counter must be able to hold TIMEOUT_CYCLES itself
  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TIMEOUT_CYCLES);

  logic             pending;
  logic [CNT_W-1:0] count;
  logic             expired;

  // Requests go downstream in the same cycle
  assign m_req = s_req;

  // Count reaches TIMEOUT_CYCLES in the cycle that is that many cycles past the request
  assign expired = pending && (count == CNT_LAST);

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      pending <= 1'b0;
      count   <= '0;
    end else if (s_req.wr || s_req.rd) begin
      // A new request starts the count at one for the following cycle
      pending <= 1'b1;
      count   <= CNT_W'(1);
    end else if (m_resp.ack || expired) begin
      pending <= 1'b0;
      count   <= '0;
    end else if (pending) begin
      count <= count + CNT_W'(1);
    end
  end

  // Downstream responses pass up as they arrive
  // On expiry the watchdog substitutes its own error response
  always_comb begin
    s_resp = m_resp;
    if (expired && !m_resp.ack) begin
      s_resp.ack    = 1'b1;
      s_resp.status = ctrlport_pkg::sts_cmderr;
      s_resp.data   = '0;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the control port subsystem testbench with Verilator and runs it
# The run passes only if the simulation prints the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ctrlport_sub_tb \
  -f ctrlport_sub.f -o ctrlport_sub_sim || { echo "Build failed"; exit 1; }
sim_out=$(./obj_dir/ctrlport_sub_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "Everything OK" && echo "Simulation passed" && exit 0 || {
  echo "Simulation did not pass"; exit 1;
}
